// ==== Makefile ====
# Verilator build for the ZX memory paging testbench

VERILATOR ?= verilator
TOP       ?= tb_zx_mem
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= *** TEST FAILED ***

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/zx_page_pkg.sv ====
`default_nettype none

package zx_page_pkg;

	//////////////////////////////////////////////////
	// bus and memory widths
	//////////////////////////////////////////////////

	localparam int ZADDR_W    = 16;
	localparam int ZDATA_W    = 8;
	localparam int WIN_CNT    = 4;
	localparam int WIN_SEL_W  = 2;
	localparam int OFFS_W     = 14;
	localparam int PAGE_W     = 7;
	localparam int MEM_ADDR_W = PAGE_W + OFFS_W;

	// high byte of the TR-DOS entry area in the 48k ROM
	localparam logic [ZDATA_W-1:0] TRAP_HI = 8'h3D;

	//////////////////////////////////////////////////
	// page register byte
	//////////////////////////////////////////////////

	// ram view, 128 pages of 16k
	typedef struct packed {
		logic              is_ram;
		logic [PAGE_W-1:0] ram_page;
	} page_ram_t;

	// rom view, bit 0 of rom_page may be taken from dos
	typedef struct packed {
		logic              is_ram;
		logic              dos_follow;
		logic [PAGE_W-2:0] rom_page;
	} page_rom_t;

	typedef union packed {
		page_ram_t ram;
		page_rom_t rom;
	} page_word_u;

	// rom, dos_follow set, rom page 0
	localparam page_word_u PAGE_RESET = 8'h40;

endpackage

`default_nettype wire

// ==== hdl/cycle_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycle_decoder #(
	parameter logic [zx_page_pkg::ZDATA_W-1:0] PAGE_PORT = 8'hF7
) (
	input  wire                                  fclk,
	input  wire                                  rst,

	input  wire                                  cyc_valid,
	output logic                                 cyc_ready,
	input  wire  [zx_page_pkg::ZADDR_W-1:0]      cyc_addr,
	input  wire  [zx_page_pkg::ZDATA_W-1:0]      cyc_wdata,
	input  wire                                  cyc_io,
	input  wire                                  cyc_wr,
	input  wire                                  cyc_m1,

	input  wire                                  fwd_ready,

	output logic [zx_page_pkg::WIN_CNT-1:0]      pg_wr,
	output zx_page_pkg::page_word_u              pg_wdata,
	output logic                                 fetch_valid,
	output logic [zx_page_pkg::WIN_SEL_W-1:0]    fetch_win,
	output logic [zx_page_pkg::ZDATA_W-1:0]      fetch_hi,

	output logic                                 fwd_valid,
	output logic [zx_page_pkg::ZADDR_W-1:0]      fwd_addr,
	output logic                                 fwd_wr,
	output logic [zx_page_pkg::ZDATA_W-1:0]      fwd_wdata
);

	import zx_page_pkg::*;

	// one-entry holding stage
	logic               st_valid;
	logic [ZADDR_W-1:0] st_addr;
	logic [ZDATA_W-1:0] st_wdata;
	logic               st_io;
	logic               st_wr;
	logic               st_m1;

	logic               rdy_en;
	logic               st_leave;
	logic               accept;
	logic               port_hit;

	//////////////////////////////////////////////////
	// stage control
	//////////////////////////////////////////////////

	// i/o cycles always leave, memory cycles wait for the mapper
	assign st_leave  = st_valid && (st_io || fwd_ready);
	assign cyc_ready = rdy_en && (!st_valid || st_leave);
	assign accept    = cyc_valid && cyc_ready;

	// ready stays low until the first edge out of reset
	always_ff @(posedge fclk)
	begin
		if (rst)
			rdy_en <= 1'b0;
		else
			rdy_en <= 1'b1;
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			st_valid <= 1'b0;
		else if (accept)
			st_valid <= 1'b1;
		else if (st_leave)
			st_valid <= 1'b0;
	end

	always_ff @(posedge fclk)
	begin
		if (accept)
		begin
			st_addr  <= cyc_addr;
			st_wdata <= cyc_wdata;
			st_io    <= cyc_io;
			st_wr    <= cyc_wr;
			st_m1    <= cyc_m1;
		end
	end

	//////////////////////////////////////////////////
	// sorting
	//////////////////////////////////////////////////

	// paging port decodes on the low address byte only
	assign port_hit = st_valid && st_io && st_wr && (st_addr[ZDATA_W-1:0] == PAGE_PORT);

	// window picked by a15:a14 of the port address
	always_comb
	begin
		pg_wr = '0;
		if (port_hit)
			pg_wr[st_addr[ZADDR_W-1 -: WIN_SEL_W]] = 1'b1;
	end

	assign pg_wdata = st_wdata;

	assign fwd_valid = st_valid && !st_io;
	assign fwd_addr  = st_addr;
	assign fwd_wr    = st_wr;
	assign fwd_wdata = st_wdata;

	// opcode fetch handed to the mapper this cycle
	assign fetch_valid = fwd_valid && fwd_ready && st_m1 && !st_wr;
	assign fetch_win   = st_addr[ZADDR_W-1 -: WIN_SEL_W];
	assign fetch_hi    = st_addr[ZADDR_W-1 -: ZDATA_W];

	// a page write leaves the stage on its own edge, so input is never held
	a_pg_wr_onehot: assert property (@(posedge fclk) disable iff (rst)
		$onehot0(pg_wr) && (pg_wr == '0 || cyc_ready))
		else $error("cycle_decoder: page write strobe not one-hot or stage held");

endmodule

`default_nettype wire

// ==== hdl/zx_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_mem_top #(
	parameter logic [zx_page_pkg::ZDATA_W-1:0] PAGE_PORT = 8'hF7
) (
	input  wire                                  fclk,
	input  wire                                  rst,

	// bus cycles from the cpu side
	input  wire                                  cyc_valid,
	output logic                                 cyc_ready,
	input  wire  [zx_page_pkg::ZADDR_W-1:0]      cyc_addr,
	input  wire  [zx_page_pkg::ZDATA_W-1:0]      cyc_wdata,
	input  wire                                  cyc_io,
	input  wire                                  cyc_wr,
	input  wire                                  cyc_m1,

	// translated memory requests
	output logic                                 mem_valid,
	input  wire                                  mem_ready,
	output logic [zx_page_pkg::MEM_ADDR_W-1:0]   mem_addr,
	output logic                                 mem_rom,
	output logic                                 mem_wr,
	output logic [zx_page_pkg::ZDATA_W-1:0]      mem_wdata,

	output logic                                 dos
);

	import zx_page_pkg::*;

	// decoder to pagers
	logic [WIN_CNT-1:0]   pg_wr;
	page_word_u           pg_wdata;
	logic                 fetch_valid;
	logic [WIN_SEL_W-1:0] fetch_win;
	logic [ZDATA_W-1:0]   fetch_hi;

	// decoder to mapper
	logic                 fwd_valid;
	logic                 fwd_ready;
	logic [ZADDR_W-1:0]   fwd_addr;
	logic                 fwd_wr;
	logic [ZDATA_W-1:0]   fwd_wdata;

	// pagers to mapper
	page_word_u           page [WIN_CNT];
	logic [WIN_CNT-1:0]   dos_on;
	logic [WIN_CNT-1:0]   dos_off;

	cycle_decoder #(
		.PAGE_PORT(PAGE_PORT)
	) u_decoder (
		.fclk       (fclk),
		.rst        (rst),
		.cyc_valid  (cyc_valid),
		.cyc_ready  (cyc_ready),
		.cyc_addr   (cyc_addr),
		.cyc_wdata  (cyc_wdata),
		.cyc_io     (cyc_io),
		.cyc_wr     (cyc_wr),
		.cyc_m1     (cyc_m1),
		.fwd_ready  (fwd_ready),
		.pg_wr      (pg_wr),
		.pg_wdata   (pg_wdata),
		.fetch_valid(fetch_valid),
		.fetch_win  (fetch_win),
		.fetch_hi   (fetch_hi),
		.fwd_valid  (fwd_valid),
		.fwd_addr   (fwd_addr),
		.fwd_wr     (fwd_wr),
		.fwd_wdata  (fwd_wdata)
	);

	// one pager per 16k window
	for (genvar i = 0; i < WIN_CNT; i++)
	begin : g_pager
		window_pager #(
			.WIN_IDX(i)
		) u_pager (
			.fclk       (fclk),
			.rst        (rst),
			.pg_wr      (pg_wr[i]),
			.pg_wdata   (pg_wdata),
			.fetch_valid(fetch_valid),
			.fetch_win  (fetch_win),
			.fetch_hi   (fetch_hi),
			.page       (page[i]),
			.dos_on     (dos_on[i]),
			.dos_off    (dos_off[i])
		);
	end

	window_mapper u_mapper (
		.fclk     (fclk),
		.rst      (rst),
		.fwd_valid(fwd_valid),
		.fwd_ready(fwd_ready),
		.fwd_addr (fwd_addr),
		.fwd_wr   (fwd_wr),
		.fwd_wdata(fwd_wdata),
		.page     (page),
		.dos_on   (dos_on),
		.dos_off  (dos_off),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr (mem_addr),
		.mem_rom  (mem_rom),
		.mem_wr   (mem_wr),
		.mem_wdata(mem_wdata),
		.dos      (dos)
	);

endmodule

`default_nettype wire

// ==== paging/window_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_mapper (
	input  wire                                  fclk,
	input  wire                                  rst,

	// memory cycles from the decoder
	input  wire                                  fwd_valid,
	output logic                                 fwd_ready,
	input  wire  [zx_page_pkg::ZADDR_W-1:0]      fwd_addr,
	input  wire                                  fwd_wr,
	input  wire  [zx_page_pkg::ZDATA_W-1:0]      fwd_wdata,

	// window state from the pagers
	input  zx_page_pkg::page_word_u              page [zx_page_pkg::WIN_CNT],
	input  wire  [zx_page_pkg::WIN_CNT-1:0]      dos_on,
	input  wire  [zx_page_pkg::WIN_CNT-1:0]      dos_off,

	// translated request
	output logic                                 mem_valid,
	input  wire                                  mem_ready,
	output logic [zx_page_pkg::MEM_ADDR_W-1:0]   mem_addr,
	output logic                                 mem_rom,
	output logic                                 mem_wr,
	output logic [zx_page_pkg::ZDATA_W-1:0]      mem_wdata,

	output logic                                 dos
);

	import zx_page_pkg::*;

	page_word_u          win_page;
	logic [PAGE_W-2:0]   rom_pg;
	logic [PAGE_W-1:0]   phys_page;
	logic                phys_rom;
	logic                load;

	//////////////////////////////////////////////////
	// translation
	//////////////////////////////////////////////////

	assign win_page = page[fwd_addr[ZADDR_W-1 -: WIN_SEL_W]];

	always_comb
	begin
		// dos picks between the two halves of a rom pair
		rom_pg = win_page.rom.rom_page;
		if (win_page.rom.dos_follow)
			rom_pg[0] = dos;

		if (win_page.ram.is_ram)
		begin
			phys_page = win_page.ram.ram_page;
			phys_rom  = 1'b0;
		end
		else
		begin
			phys_page = {1'b0, rom_pg};
			phys_rom  = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	assign fwd_ready = !mem_valid || mem_ready;
	assign load      = fwd_valid && fwd_ready;

	always_ff @(posedge fclk)
	begin
		if (rst)
			mem_valid <= 1'b0;
		else if (load)
			mem_valid <= 1'b1;
		else if (mem_ready)
			mem_valid <= 1'b0;
	end

	always_ff @(posedge fclk)
	begin
		if (load)
		begin
			mem_addr  <= {phys_page, fwd_addr[OFFS_W-1:0]};
			mem_rom   <= phys_rom;
			mem_wr    <= fwd_wr;
			mem_wdata <= fwd_wdata;
		end
	end

	// dos flag, the trapping fetch was translated with the old value
	always_ff @(posedge fclk)
	begin
		if (rst)
			dos <= 1'b0;
		else if (|dos_on)
			dos <= 1'b1;
		else if (|dos_off)
			dos <= 1'b0;
	end

	a_mem_hold: assert property (@(posedge fclk) disable iff (rst)
		mem_valid && !mem_ready |=>
			mem_valid && $stable({mem_addr, mem_rom, mem_wr, mem_wdata}))
		else $error("window_mapper: request changed while stalled");

endmodule

`default_nettype wire

// ==== paging/window_pager.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_pager #(
	parameter int WIN_IDX = 0
) (
	input  wire                                  fclk,
	input  wire                                  rst,

	// page register load from the decoder
	input  wire                                  pg_wr,
	input  zx_page_pkg::page_word_u              pg_wdata,

	// opcode fetch leaving the decoder
	input  wire                                  fetch_valid,
	input  wire  [zx_page_pkg::WIN_SEL_W-1:0]    fetch_win,
	input  wire  [zx_page_pkg::ZDATA_W-1:0]      fetch_hi,

	output zx_page_pkg::page_word_u              page,
	output logic                                 dos_on,
	output logic                                 dos_off
);

	import zx_page_pkg::*;

	localparam logic [WIN_SEL_W-1:0] MY_WIN = WIN_SEL_W'(WIN_IDX);

	logic fetch_hit;
	logic trap_hit;

	//////////////////////////////////////////////////
	// page register
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
			page <= PAGE_RESET;
		else if (pg_wr)
			page <= pg_wdata;
	end

	//////////////////////////////////////////////////
	// dos trap detection
	//////////////////////////////////////////////////

	// fetch from this window
	assign fetch_hit = fetch_valid && (fetch_win == MY_WIN);

	// 3Dxx only matters while rom is mapped here
	assign trap_hit = fetch_hit && (fetch_hi == TRAP_HI);

	// requests use the page word before any write on this edge
	assign dos_on  = trap_hit && !page.rom.is_ram;
	assign dos_off = fetch_hit && page.ram.is_ram;

	// executing out of ram leaves dos, rom at 3Dxx enters it
	// a fetch and a page write never share an edge
	a_dos_req_excl: assert property (@(posedge fclk) disable iff (rst)
		!(dos_on && dos_off) && !(pg_wr && fetch_valid))
		else $error("window_pager %0d: dos requests clash or fetch meets page write", WIN_IDX);

endmodule

`default_nettype wire

// ==== verif/tb_zx_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zx_mem;

	import zx_page_pkg::*;

	localparam logic [ZDATA_W-1:0] PAGE_PORT = 8'hF7;
	localparam logic [31:0]        SEED      = 32'h94e5_b0a8;

	// bus cycles per test, they set the run limit
	localparam int N_RESET_RD  = 8;
	localparam int N_RAM       = 12;
	localparam int N_ROM       = 6;
	localparam int N_DOS       = 7;
	localparam int N_RAND      = 200;
	localparam int STIM_CYCLES = N_RESET_RD + N_RAM + N_ROM + N_DOS + N_RAND;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 200;
	localparam int DRAIN_MAX   = 100;
	localparam int N_TESTS     = 5;

	logic                  fclk;
	logic                  rst;
	logic                  cyc_valid;
	logic                  cyc_ready;
	logic [ZADDR_W-1:0]    cyc_addr;
	logic [ZDATA_W-1:0]    cyc_wdata;
	logic                  cyc_io;
	logic                  cyc_wr;
	logic                  cyc_m1;
	logic                  mem_valid;
	logic                  mem_ready;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic                  mem_rom;
	logic                  mem_wr;
	logic [ZDATA_W-1:0]    mem_wdata;
	logic                  dos;

	// reference state and expected requests
	page_word_u            model_page [WIN_CNT];
	logic                  model_dos;
	logic                  exp_valid;
	logic [MEM_ADDR_W-1:0] exp_addr;
	logic                  exp_rom;
	logic                  exp_wr;
	logic [ZDATA_W-1:0]    exp_wdata;
	logic                  test_done;
	logic [7:0]            test_num;
	logic                  rand_ready;
	int                    pending;
	int                    err_count;
	int                    chk_count;

	zx_mem_top #(
		.PAGE_PORT(PAGE_PORT)
	) UUT (
		.fclk(fclk), .rst(rst),
		.cyc_valid(cyc_valid), .cyc_ready(cyc_ready), .cyc_addr(cyc_addr),
		.cyc_wdata(cyc_wdata), .cyc_io(cyc_io), .cyc_wr(cyc_wr), .cyc_m1(cyc_m1),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
		.mem_rom(mem_rom), .mem_wr(mem_wr), .mem_wdata(mem_wdata), .dos(dos)
	);

	zx_mem_checker u_checker (
		.fclk(fclk), .rst(rst),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
		.mem_rom(mem_rom), .mem_wr(mem_wr), .mem_wdata(mem_wdata), .dos(dos),
		.exp_valid(exp_valid), .exp_addr(exp_addr), .exp_rom(exp_rom),
		.exp_wr(exp_wr), .exp_wdata(exp_wdata), .exp_dos(model_dos),
		.test_done(test_done), .test_num(test_num),
		.pending(pending), .err_count(err_count), .chk_count(chk_count)
	);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// physical page times 16k plus offset, rom flag on top
	function automatic logic [MEM_ADDR_W:0] ref_translate(input page_word_u pw,
		input logic [ZADDR_W-1:0] zaddr, input logic dos_now);
		int unsigned pg;
		int unsigned offs;
		offs = 32'(zaddr) % 16384;
		if (pw.ram.is_ram)
		begin
			pg = 32'(pw.ram.ram_page);
			return {1'b0, MEM_ADDR_W'(pg * 16384 + offs)};
		end
		pg = 32'(pw.rom.rom_page);
		if (pw.rom.dos_follow)
			pg = (pg & ~32'd1) | 32'(dos_now);
		return {1'b1, MEM_ADDR_W'(pg * 16384 + offs)};
	endfunction

	// state follows the order in which cycles are accepted
	always @(posedge fclk)
	begin : model
		logic [MEM_ADDR_W:0] xl;
		page_word_u          pw;
		exp_valid <= 1'b0;
		if (rst)
		begin
			for (int w = 0; w < WIN_CNT; w++)
				model_page[w] = PAGE_RESET;
			model_dos = 1'b0;
		end
		else if (cyc_valid && cyc_ready)
		begin
			if (cyc_io)
			begin
				if (cyc_wr && cyc_addr[7:0] == PAGE_PORT)
					model_page[cyc_addr[15:14]] = cyc_wdata;
			end
			else
			begin
				pw = model_page[cyc_addr[15:14]];
				xl = ref_translate(pw, cyc_addr, model_dos);
				exp_valid <= 1'b1;
				exp_rom   <= xl[MEM_ADDR_W];
				exp_addr  <= xl[MEM_ADDR_W-1:0];
				exp_wr    <= cyc_wr;
				exp_wdata <= cyc_wdata;
				// trapping fetch already translated with the old flag
				if (cyc_m1 && !cyc_wr)
				begin
					if (!pw.ram.is_ram && cyc_addr[15:8] == TRAP_HI)
						model_dos = 1'b1;
					else if (pw.ram.is_ram)
						model_dos = 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////

	task automatic next_edge();
		@(posedge fclk);
		if (rand_ready)
			mem_ready <= (($urandom % 4) != 0);
	endtask

	task automatic bus_cycle(input logic [ZADDR_W-1:0] addr, input logic [ZDATA_W-1:0] wdata,
		input logic io, input logic wr, input logic m1);
		cyc_valid <= 1'b1;
		cyc_addr  <= addr;
		cyc_wdata <= wdata;
		cyc_io    <= io;
		cyc_wr    <= wr;
		cyc_m1    <= m1;
		next_edge();
		while (!cyc_ready)
			next_edge();
	endtask

	task automatic page_write(input logic [1:0] win, input logic [ZDATA_W-1:0] data);
		bus_cycle({win, 6'h15, PAGE_PORT}, data, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic mem_read(input logic [ZADDR_W-1:0] addr);
		bus_cycle(addr, 8'h00, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic mem_write(input logic [ZADDR_W-1:0] addr, input logic [ZDATA_W-1:0] data);
		bus_cycle(addr, data, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic opcode_fetch(input logic [ZADDR_W-1:0] addr);
		bus_cycle(addr, 8'h00, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic idle_cycle();
		cyc_valid <= 1'b0;
		next_edge();
	endtask

	// wait for the expected queue to empty, then let the checker close the test
	task automatic finish_test(input logic [7:0] t);
		int n;
		n = 0;
		idle_cycle();
		next_edge();
		while (pending != 0 && n < DRAIN_MAX)
		begin
			next_edge();
			n++;
		end
		repeat (2) next_edge();
		test_num  <= t;
		test_done <= 1'b1;
		next_edge();
		test_done <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	initial
	begin : stimulus
		int unsigned        kind;
		logic [31:0]        r;
		logic [ZADDR_W-1:0] a;
		void'($urandom(SEED));
		rst        = 1'b1;
		cyc_valid  = 1'b0;
		cyc_addr   = '0;
		cyc_wdata  = '0;
		cyc_io     = 1'b0;
		cyc_wr     = 1'b0;
		cyc_m1     = 1'b0;
		mem_ready  = 1'b1;
		test_done  = 1'b0;
		test_num   = '0;
		rand_ready = 1'b0;
		repeat (5) @(posedge fclk);
		rst <= 1'b0;
		next_edge();

		// reset mapping, rom page 0 everywhere
		for (int w = 0; w < WIN_CNT; w++)
		begin
			mem_read({2'(w), 14'h0000});
			mem_read({2'(w), 14'h2A5C});
		end
		finish_test(8'd1);

		// ram pages in all windows
		page_write(2'd0, 8'h83);
		page_write(2'd1, 8'h8C);
		page_write(2'd2, 8'hA5);
		page_write(2'd3, 8'hFF);
		mem_read(16'h0123);
		mem_write(16'h3FFF, 8'h5A);
		mem_read(16'h4000);
		mem_write(16'h6B21, 8'hC3);
		mem_read(16'h8001);
		mem_read(16'hA5A5);
		mem_write(16'hC777, 8'h0F);
		mem_read(16'hFFFE);
		finish_test(8'd2);

		// rom with and without dos_follow
		page_write(2'd0, 8'h05);
		page_write(2'd1, 8'h4B);
		mem_read(16'h0010);
		mem_read(16'h3D00);
		mem_read(16'h4321);
		mem_read(16'h7FF0);
		finish_test(8'd3);

		// trap at 3Dxx sets dos, a fetch from ram clears it
		page_write(2'd0, 8'h40);
		page_write(2'd3, 8'h85);
		opcode_fetch(16'h3D2F);
		mem_read(16'h0100);
		mem_read(16'h4123);
		opcode_fetch(16'hC010);
		mem_read(16'h0200);
		finish_test(8'd4);

		// random mix under random back-pressure
		rand_ready = 1'b1;
		for (int i = 0; i < N_RAND; i++)
		begin
			kind = $urandom % 8;
			r    = $urandom;
			a    = r[15:0];
			case (kind)
				0: idle_cycle();
				1: page_write(a[15:14], r[23:16]);
				2:
				begin
					if (a[7:0] == PAGE_PORT)
						a[0] = ~a[0];
					bus_cycle(a, r[23:16], 1'b1, 1'b1, 1'b0);
				end
				3:
				begin
					if (r[31])
						a[7:0] = PAGE_PORT;
					bus_cycle(a, r[23:16], 1'b1, 1'b0, 1'b0);
				end
				4: mem_write(a, r[23:16]);
				5, 6: mem_read(a);
				default:
				begin
					if (r[31:30] == 2'b00)
						a[15:8] = TRAP_HI;
					opcode_fetch(a);
				end
			endcase
		end
		rand_ready = 1'b0;
		mem_ready <= 1'b1;
		finish_test(8'd5);

		next_edge();
		$display("tests %0d, requests checked %0d, errors %0d", N_TESTS, chk_count, err_count);
		if (err_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin : watchdog
		int cycle_cnt;
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge fclk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/zx_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_mem_checker (
	input  wire                                  fclk,
	input  wire                                  rst,

	// DUT memory port
	input  wire                                  mem_valid,
	input  wire                                  mem_ready,
	input  wire  [zx_page_pkg::MEM_ADDR_W-1:0]   mem_addr,
	input  wire                                  mem_rom,
	input  wire                                  mem_wr,
	input  wire  [zx_page_pkg::ZDATA_W-1:0]      mem_wdata,
	input  wire                                  dos,

	// expected requests from the reference model
	input  wire                                  exp_valid,
	input  wire  [zx_page_pkg::MEM_ADDR_W-1:0]   exp_addr,
	input  wire                                  exp_rom,
	input  wire                                  exp_wr,
	input  wire  [zx_page_pkg::ZDATA_W-1:0]      exp_wdata,
	input  wire                                  exp_dos,

	input  wire                                  test_done,
	input  wire  [7:0]                           test_num,

	output int                                   pending,
	output int                                   err_count,
	output int                                   chk_count
);

	import zx_page_pkg::*;

	localparam int REQ_W = MEM_ADDR_W + ZDATA_W + 2;

	// {rom, wr, wdata, addr}
	logic [REQ_W-1:0] exp_q [$];
	int               test_chk;
	int               test_err;

	task automatic field_error(input string name, input logic [31:0] expv,
		input logic [31:0] gotv);
		$display("[ERROR] %s expected %h got %h", name, expv, gotv);
		err_count++;
		test_err++;
	endtask

	always @(posedge fclk)
	begin : compare
		logic [REQ_W-1:0] head;
		if (rst)
		begin
			exp_q.delete();
			err_count = 0;
			chk_count = 0;
			test_chk  = 0;
			test_err  = 0;
		end
		else
		begin
			// push first, a request never leaves on the edge it is queued
			if (exp_valid)
				exp_q.push_back({exp_rom, exp_wr, exp_wdata, exp_addr});

			if (mem_valid && mem_ready)
			begin
				if (exp_q.size() == 0)
				begin
					$display("extra memory request at %h with no cycle waiting for it", mem_addr);
					err_count++;
					test_err++;
				end
				else
				begin
					head = exp_q.pop_front();
					chk_count++;
					test_chk++;
					if (mem_addr !== head[MEM_ADDR_W-1:0])
						field_error("mem_addr", 32'(head[MEM_ADDR_W-1:0]), 32'(mem_addr));
					if (mem_wdata !== head[MEM_ADDR_W +: ZDATA_W])
						field_error("mem_wdata", 32'(head[MEM_ADDR_W +: ZDATA_W]), 32'(mem_wdata));
					if (mem_wr !== head[REQ_W-2])
						field_error("mem_wr", 32'(head[REQ_W-2]), 32'(mem_wr));
					if (mem_rom !== head[REQ_W-1])
						field_error("mem_rom", 32'(head[REQ_W-1]), 32'(mem_rom));
				end
			end

			if (test_done)
			begin
				if (exp_q.size() != 0)
				begin
					$display("test %0d: %0d memory requests never appeared", test_num, exp_q.size());
					err_count += exp_q.size();
					test_err  += exp_q.size();
					exp_q.delete();
				end
				if (dos !== exp_dos)
					field_error("dos", 32'(exp_dos), 32'(dos));
				$display("test %0d done: %0d requests checked, %0d errors",
					test_num, test_chk, test_err);
				test_chk = 0;
				test_err = 0;
			end
		end
		pending <= exp_q.size();
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/zx_page_pkg.sv
paging/window_pager.sv
paging/window_mapper.sv
hdl/cycle_decoder.sv
hdl/zx_mem_top.sv
verif/zx_mem_checker.sv
verif/tb_zx_mem.sv
